/* all.f */
design/soc_bus_pkg.sv
design/bus_decoder.sv
design/data_ram.sv
design/bus_timer.sv
design/gpio_bank.sv
design/rdata_mux.sv
design/periph_bus.sv
tb/bus_assertions.sv
tb/bus_checker.sv
tb/tb_periph_bus.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_periph_bus \
    -f all.f -o sim_periph_bus \
    && ./obj_dir/sim_periph_bus +verilator+error+limit+1000 > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || exit 1
exit 0

/* tb/tb_periph_bus.sv */
`timescale 1ns/10ps

module tb_periph_bus import soc_bus_pkg::*; ();

    localparam int BANKS   = 4;
    localparam int RAM_WIN = 32;
    localparam int N_RAM   = 160;
    localparam int N_MIXED = 300;
    localparam int N_RSVD  = 40;
    // cycle budget of all five tests, watchdog adds a margin on top
    localparam int TOTAL_CYCLES = 4 * RAM_WIN + 2 * N_RAM + N_MIXED + 24 * BANKS
                                  + 80 + 4 * N_RSVD + 2 * RAM_WIN;
    localparam int TIMEOUT_NS = (TOTAL_CYCLES + 200) * 20;

    logic                         clk_i;
    logic                         rst_n_i;
    logic                         data_req_i;
    logic                         data_we_i;
    logic [3:0]                   data_be_i;
    logic [ADDR_W-1:0]            data_addr_i;
    logic [DATA_W-1:0]            data_wdata_i;
    logic                         irq_ack_i;
    logic [BANKS-1:0][GPIO_W-1:0] gpio_in_i;
    logic                         data_gnt_o;
    logic                         data_rvalid_o;
    logic [DATA_W-1:0]            data_rdata_o;
    logic                         irq_o;
    logic [BANKS-1:0][GPIO_W-1:0] gpio_out_o;

    int          seed = 20;
    int          tb_errors = 0;
    int          tests_run = 0;
    int unsigned last_checks = 0;
    int unsigned last_errors = 0;
    int unsigned total_errors;

    periph_bus #(.GPIO_BANKS(BANKS)) u_dut (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .data_req_i(data_req_i), .data_we_i(data_we_i), .data_be_i(data_be_i),
        .data_addr_i(data_addr_i), .data_wdata_i(data_wdata_i), .irq_ack_i(irq_ack_i),
        .gpio_in_i(gpio_in_i), .data_gnt_o(data_gnt_o), .data_rvalid_o(data_rvalid_o),
        .data_rdata_o(data_rdata_o), .irq_o(irq_o), .gpio_out_o(gpio_out_o)
    );

    bus_checker #(.GPIO_BANKS(BANKS)) u_checker (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .req_i(data_req_i), .we_i(data_we_i),
        .be_i(data_be_i), .addr_i(data_addr_i), .wdata_i(data_wdata_i),
        .irq_ack_i(irq_ack_i), .gpio_in_i(gpio_in_i), .gnt_i(data_gnt_o),
        .rvalid_i(data_rvalid_o), .rdata_i(data_rdata_o), .irq_i(irq_o),
        .gpio_out_i(gpio_out_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, tests did not finish", TIMEOUT_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    // region code in bits 16:13, word index in bits 12:2
    function automatic logic [31:0] make_addr(input int code, input int word);
        return {15'd0, code[3:0], word[10:0], 2'b00};
    endfunction

    function automatic int reserved_code();
        if (BANKS == 13 || ({$random(seed)} % 2) == 0) begin
            return 1;
        end
        return 3 + BANKS + {$random(seed)} % (13 - BANKS);
    endfunction

    function automatic logic [31:0] random_addr();
        int kind;
        int r;
        kind = {$random(seed)} % 4;
        r    = {$random(seed)} % 4;
        case (kind)
            0:       return make_addr(0, {$random(seed)} % RAM_WIN);
            1:       return make_addr(2, r);
            2:       return make_addr(3 + {$random(seed)} % BANKS, r);
            default: return make_addr(reserved_code(), r);
        endcase
    endfunction

    task automatic issue_request(input logic we, input logic [3:0] be,
                                 input logic [31:0] addr, input logic [31:0] wdata);
        @(posedge clk_i);
        data_req_i   <= 1'b1;
        data_we_i    <= we;
        data_be_i    <= be;
        data_addr_i  <= addr;
        data_wdata_i <= wdata;
    endtask

    task automatic hold_idle(input int n);
        repeat (n) begin
            @(posedge clk_i);
            data_req_i <= 1'b0;
            data_we_i  <= 1'b0;
            irq_ack_i  <= 1'b0;
        end
    endtask

    task automatic pulse_ack();
        @(posedge clk_i);
        data_req_i <= 1'b0;
        data_we_i  <= 1'b0;
        irq_ack_i  <= 1'b1;
        @(posedge clk_i);
        irq_ack_i  <= 1'b0;
    endtask

    // drain the pipeline, then read the counters between edges
    task automatic end_test(input string name);
        int unsigned errs;
        hold_idle(3);
        @(negedge clk_i);
        errs = u_checker.error_count + tb_errors - last_errors;
        $display("test %-9s done: %0d checks, %0d errors", name,
                 u_checker.check_count - last_checks, errs);
        last_checks = u_checker.check_count;
        last_errors = u_checker.error_count + tb_errors;
        tests_run++;
    endtask

    task automatic ram_test();
        for (int w = 0; w < RAM_WIN; w++) begin
            issue_request(1'b1, 4'hf, make_addr(0, w), $random(seed));
            hold_idle(1);
        end
        for (int i = 0; i < N_RAM; i++) begin
            issue_request(1'b1, 4'($random(seed)), make_addr(0, {$random(seed)} % RAM_WIN),
                          $random(seed));
            hold_idle(1);
        end
        for (int w = 0; w < RAM_WIN; w++) begin
            issue_request(1'b0, 4'hf, make_addr(0, w), 32'd0);
            hold_idle(1);
        end
        end_test("ram");
    endtask

    // a request every cycle, pins and ack move too
    task automatic mixed_test();
        for (int i = 0; i < N_MIXED; i++) begin
            issue_request(1'($random(seed)), 4'($random(seed)), random_addr(), $random(seed));
            irq_ack_i <= ({$random(seed)} % 8) == 0;
            for (int b = 0; b < BANKS; b++) begin
                gpio_in_i[b] <= 16'($random(seed));
            end
        end
        end_test("mixed");
    endtask

    task automatic gpio_test();
        for (int b = 0; b < BANKS; b++) begin
            issue_request(1'b1, 4'($random(seed)), make_addr(3 + b, 0), $random(seed));
            hold_idle(1);
        end
        @(posedge clk_i);
        for (int b = 0; b < BANKS; b++) begin
            gpio_in_i[b] <= 16'($random(seed));
        end
        hold_idle(3);
        for (int b = 0; b < BANKS; b++) begin
            issue_request(1'b0, 4'hf, make_addr(3 + b, 1), 32'd0);
            issue_request(1'b0, 4'hf, make_addr(3 + b, 0), 32'd0);
        end
        end_test("gpio");
    endtask

    task automatic timer_test();
        int k;
        int waited;
        k = 4 + {$random(seed)} % 16;
        issue_request(1'b1, 4'hf, make_addr(2, 2), 32'd0);
        issue_request(1'b1, 4'hf, make_addr(2, 0), 32'd0);
        issue_request(1'b1, 4'hf, make_addr(2, 1), k);
        pulse_ack();
        issue_request(1'b1, 4'hf, make_addr(2, 2), 32'd3);
        waited = 0;
        // count reads while waiting for the match
        while (irq_o !== 1'b1 && waited < k + 10) begin
            issue_request(1'b0, 4'hf, make_addr(2, 0), 32'd0);
            waited++;
        end
        if (irq_o !== 1'b1) begin
            tb_errors++;
            $display("[FAIL] %0t irq_o never rose within %0d cycles of the timer enable",
                     $time, k + 10);
        end
        hold_idle(4);
        pulse_ack();
        hold_idle(3);
        issue_request(1'b1, 4'hf, make_addr(2, 2), 32'd0);
        end_test("timer");
    endtask

    task automatic reserved_test();
        for (int i = 0; i < N_RSVD; i++) begin
            issue_request(1'b1, 4'hf, make_addr(reserved_code(), {$random(seed)} % RAM_WIN),
                          $random(seed));
            hold_idle(1);
            issue_request(1'b0, 4'hf, make_addr(reserved_code(), {$random(seed)} % 4),
                          32'd0);
            hold_idle(1);
        end
        // nothing else may have moved
        for (int w = 0; w < RAM_WIN; w++) begin
            issue_request(1'b0, 4'hf, make_addr(0, w), 32'd0);
        end
        for (int off = 0; off < 3; off++) begin
            issue_request(1'b0, 4'hf, make_addr(2, off), 32'd0);
        end
        for (int b = 0; b < BANKS; b++) begin
            issue_request(1'b0, 4'hf, make_addr(3 + b, 0), 32'd0);
        end
        end_test("reserved");
    endtask

    initial begin
        rst_n_i      = 1'b0;
        data_req_i   = 1'b0;
        data_we_i    = 1'b0;
        data_be_i    = 4'h0;
        data_addr_i  = '0;
        data_wdata_i = '0;
        irq_ack_i    = 1'b0;
        gpio_in_i    = '0;
        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;
        ram_test();
        mixed_test();
        gpio_test();
        timer_test();
        reserved_test();
        total_errors = u_checker.error_count + tb_errors + u_dut.u_assertions.fail_count;
        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d", tests_run,
                 u_checker.check_count, total_errors, u_dut.u_assertions.fail_count);
        if (total_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* tb/bus_checker.sv */
`timescale 1ns/10ps

module bus_checker import soc_bus_pkg::*; #(
    parameter int GPIO_BANKS = 4
) (
    input logic                              clk_i,
    input logic                              rst_n_i,
    input logic                              req_i,
    input logic                              we_i,
    input logic [3:0]                        be_i,
    input logic [ADDR_W-1:0]                 addr_i,
    input logic [DATA_W-1:0]                 wdata_i,
    input logic                              irq_ack_i,
    input logic [GPIO_BANKS-1:0][GPIO_W-1:0] gpio_in_i,
    input logic                              gnt_i,
    input logic                              rvalid_i,
    input logic [DATA_W-1:0]                 rdata_i,
    input logic                              irq_i,
    input logic [GPIO_BANKS-1:0][GPIO_W-1:0] gpio_out_i
);

    int unsigned check_count = 0;
    int unsigned error_count = 0;

    logic [31:0] ram_m [RAM_WORDS];
    logic [31:0] cnt_m;
    logic [31:0] cmp_m;
    logic [1:0]  ctrl_m;
    logic        irq_m;
    logic [15:0] out_m  [GPIO_BANKS];
    logic [15:0] meta_m [GPIO_BANKS];
    logic [15:0] sync_m [GPIO_BANKS];
    logic [31:0] exp_q  [$];

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  be);
        logic [31:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic logic [31:0] read_model(input logic [31:0] addr);
        int code;
        int off;
        code = int'(addr[16:13]);
        off  = int'(addr[3:2]);
        if (code == 0) begin
            return ram_m[addr[12:2]];
        end else if (code == 2) begin
            if (off == 0) return cnt_m;
            if (off == 1) return cmp_m;
            if (off == 2) return {30'd0, ctrl_m};
        end else if (code >= 3 && code < 3 + GPIO_BANKS) begin
            if (off == 0) return {16'd0, out_m[code - 3]};
            if (off == 1) return {16'd0, sync_m[code - 3]};
        end
        return 32'd0;
    endfunction

    // count write wins, merged against the value before the increment
    task automatic apply_write(input logic [31:0] addr, input logic [3:0] be,
                               input logic [31:0] wdata, input logic [31:0] cnt_old);
        int          code;
        int          off;
        logic [31:0] tmp;
        code = int'(addr[16:13]);
        off  = int'(addr[3:2]);
        if (code == 0) begin
            ram_m[addr[12:2]] = merge_bytes(ram_m[addr[12:2]], wdata, be);
        end else if (code == 2) begin
            if (off == 0) cnt_m = merge_bytes(cnt_old, wdata, be);
            if (off == 1) cmp_m = merge_bytes(cmp_m, wdata, be);
            if (off == 2) begin
                tmp    = merge_bytes({30'd0, ctrl_m}, wdata, be);
                ctrl_m = tmp[1:0];
            end
        end else if (code >= 3 && code < 3 + GPIO_BANKS && off == 0) begin
            tmp = merge_bytes({16'd0, out_m[code - 3]}, wdata, {2'b00, be[1:0]});
            out_m[code - 3] = tmp[15:0];
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp_w,
                              input logic [31:0] act_w);
        check_count++;
        if (act_w !== exp_w) begin
            error_count++;
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp_w, act_w);
        end
    endtask

    always @(posedge clk_i) begin
        logic [31:0] exp_w;
        logic [31:0] cnt_old;
        logic        match;
        if (!rst_n_i) begin
            cnt_m  = '0;
            cmp_m  = '0;
            ctrl_m = '0;
            irq_m  = 1'b0;
            for (int b = 0; b < GPIO_BANKS; b++) begin
                out_m[b]  = '0;
                meta_m[b] = '0;
                sync_m[b] = '0;
            end
            exp_q.delete();
        end else begin
            // outputs left by the previous edge
            check_word("data_gnt_o", 32'd1, {31'd0, gnt_i});
            if (rvalid_i === 1'b1) begin
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("[FAIL] %0t data_rvalid_o came with no request outstanding", $time);
                end else begin
                    exp_w = exp_q.pop_front();
                    if (!$isunknown(exp_w)) begin
                        check_word("data_rdata_o", exp_w, rdata_i);
                    end
                end
            end else if (exp_q.size() != 0) begin
                error_count++;
                $display("[FAIL] %0t request got no data_rvalid_o one cycle later", $time);
                exp_q.delete();
            end
            check_word("irq_o", {31'd0, irq_m}, {31'd0, irq_i});
            for (int b = 0; b < GPIO_BANKS; b++) begin
                check_word($sformatf("gpio_out_o[%0d]", b), {16'd0, out_m[b]},
                           {16'd0, gpio_out_i[b]});
            end
            // then this edge's request
            if (req_i) begin
                exp_q.push_back(read_model(addr_i));
            end
            match   = ctrl_m[1] && (cnt_m == cmp_m);
            cnt_old = cnt_m;
            if (ctrl_m[0]) begin
                cnt_m = cnt_m + 32'd1;
            end
            if (irq_ack_i) begin
                irq_m = 1'b0;
            end else if (match) begin
                irq_m = 1'b1;
            end
            if (req_i && we_i) begin
                apply_write(addr_i, be_i, wdata_i, cnt_old);
            end
            for (int b = 0; b < GPIO_BANKS; b++) begin
                sync_m[b] = meta_m[b];
                meta_m[b] = gpio_in_i[b];
            end
        end
    end

endmodule

/* tb/bus_assertions.sv */
`timescale 1ns/10ps

module bus_assertions (
    input logic clk_i,
    input logic rst_n_i,
    input logic req_i,
    input logic gnt_i,
    input logic rvalid_i,
    input logic irq_i,
    input logic ack_i
);

    int unsigned fail_count = 0;

    // one rvalid per request, exactly one cycle later
    rvalid_follows_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rvalid_i == $past(req_i))
        else begin
            $error("data_rvalid_o does not match data_req_i of the previous cycle");
            fail_count++;
        end

    gnt_always_high: assert property (@(posedge clk_i) disable iff (!rst_n_i) gnt_i)
        else begin
            $error("data_gnt_o dropped low");
            fail_count++;
        end

    // sticky until acknowledged
    irq_held_until_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        irq_i && !ack_i |=> irq_i)
        else begin
            $error("irq_o fell without irq_ack_i");
            fail_count++;
        end

endmodule

bind periph_bus bus_assertions u_assertions (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .req_i(data_req_i), .gnt_i(data_gnt_o),
    .rvalid_i(data_rvalid_o), .irq_i(irq_o), .ack_i(irq_ack_i)
);

/* design/periph_bus.sv */
`timescale 1ns/10ps

module periph_bus import soc_bus_pkg::*; #(
    parameter int GPIO_BANKS = 4
) (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              data_req_i,
    input  logic                              data_we_i,
    input  logic [3:0]                        data_be_i,
    input  logic [ADDR_W-1:0]                 data_addr_i,
    input  logic [DATA_W-1:0]                 data_wdata_i,
    input  logic                              irq_ack_i,
    input  logic [GPIO_BANKS-1:0][GPIO_W-1:0] gpio_in_i,
    output logic                              data_gnt_o,
    output logic                              data_rvalid_o,
    output logic [DATA_W-1:0]                 data_rdata_o,
    output logic                              irq_o,
    output logic [GPIO_BANKS-1:0][GPIO_W-1:0] gpio_out_o
);

    logic                              ram_we;
    logic                              timer_we;
    logic [GPIO_BANKS-1:0]             gpio_we;
    region_e                           rd_region;
    logic [3:0]                        rd_bank;
    logic [DATA_W-1:0]                 ram_rdata;
    logic [DATA_W-1:0]                 timer_rdata;
    logic [GPIO_BANKS-1:0][DATA_W-1:0] gpio_rdata;

    // no wait states
    assign data_gnt_o = 1'b1;

    bus_decoder #(.GPIO_BANKS(GPIO_BANKS)) u_decoder (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .req_i(data_req_i), .we_i(data_we_i), .addr_i(data_addr_i),
        .ram_we_o(ram_we), .timer_we_o(timer_we), .gpio_we_o(gpio_we),
        .rd_region_o(rd_region), .rd_bank_o(rd_bank)
    );

    data_ram u_ram (
        .clk_i(clk_i), .we_i(ram_we), .be_i(data_be_i),
        .addr_i(data_addr_i[12:2]), .wdata_i(data_wdata_i), .rdata_o(ram_rdata)
    );

    bus_timer u_timer (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .we_i(timer_we), .be_i(data_be_i),
        .addr_i(data_addr_i[3:2]), .wdata_i(data_wdata_i), .irq_ack_i(irq_ack_i),
        .rdata_o(timer_rdata), .irq_o(irq_o)
    );

    for (genvar g = 0; g < GPIO_BANKS; g++) begin : g_gpio
        gpio_bank u_gpio (
            .clk_i(clk_i), .rst_n_i(rst_n_i), .we_i(gpio_we[g]), .be_i(data_be_i),
            .addr_i(data_addr_i[3:2]), .wdata_i(data_wdata_i),
            .gpio_in_i(gpio_in_i[g]), .rdata_o(gpio_rdata[g]),
            .gpio_out_o(gpio_out_o[g])
        );
    end

    rdata_mux #(.GPIO_BANKS(GPIO_BANKS)) u_rdata_mux (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .req_i(data_req_i),
        .rd_region_i(rd_region), .rd_bank_i(rd_bank),
        .ram_rdata_i(ram_rdata), .timer_rdata_i(timer_rdata), .gpio_rdata_i(gpio_rdata),
        .data_rvalid_o(data_rvalid_o), .data_rdata_o(data_rdata_o)
    );

endmodule

/* design/rdata_mux.sv */
`timescale 1ns/10ps

module rdata_mux import soc_bus_pkg::*; #(
    parameter int GPIO_BANKS = 4
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                req_i,
    input  region_e                             rd_region_i,
    input  logic [3:0]                          rd_bank_i,
    input  logic [DATA_W-1:0]                   ram_rdata_i,
    input  logic [DATA_W-1:0]                   timer_rdata_i,
    input  logic [GPIO_BANKS-1:0][DATA_W-1:0]   gpio_rdata_i,
    output logic                                data_rvalid_o,
    output logic [DATA_W-1:0]                   data_rdata_o
);

    logic [DATA_W-1:0]                 timer_q;
    logic [GPIO_BANKS-1:0][DATA_W-1:0] gpio_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            data_rvalid_o <= 1'b0;
        end else begin
            data_rvalid_o <= req_i;
        end
    end

    // snapshot of the register words at the request edge
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            timer_q <= timer_rdata_i;
            gpio_q  <= gpio_rdata_i;
        end
    end

    // ram word is already registered inside the ram
    always_comb begin
        data_rdata_o = '0;
        case (rd_region_i)
            REG_RAM:   data_rdata_o = ram_rdata_i;
            REG_TIMER: data_rdata_o = timer_q;
            REG_GPIO0: begin
                if (int'(rd_bank_i) < GPIO_BANKS) begin
                    data_rdata_o = gpio_q[rd_bank_i];
                end
            end
            default:   data_rdata_o = '0;
        endcase
    end

endmodule

/* design/gpio_bank.sv */
`timescale 1ns/10ps

module gpio_bank import soc_bus_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              we_i,
    input  logic [3:0]        be_i,
    input  logic [1:0]        addr_i,
    input  logic [DATA_W-1:0] wdata_i,
    input  logic [GPIO_W-1:0] gpio_in_i,
    output logic [DATA_W-1:0] rdata_o,
    output logic [GPIO_W-1:0] gpio_out_o
);

    logic [GPIO_W-1:0] out_q;
    logic [GPIO_W-1:0] in_meta_q;
    logic [GPIO_W-1:0] in_sync_q;
    logic [DATA_W-1:0] out_next;

    // only the low two lanes reach the output register
    assign out_next = apply_be({{(DATA_W-GPIO_W){1'b0}}, out_q}, wdata_i,
                               {2'b00, be_i[1:0]});

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_q <= '0;
        end else if (we_i && addr_i == 2'd0) begin
            out_q <= out_next[GPIO_W-1:0];
        end
    end

    // two-stage synchronizer on the pins
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            in_meta_q <= '0;
            in_sync_q <= '0;
        end else begin
            in_meta_q <= gpio_in_i;
            in_sync_q <= in_meta_q;
        end
    end

    assign gpio_out_o = out_q;

    always_comb begin
        case (addr_i)
            2'd0:    rdata_o = {{(DATA_W-GPIO_W){1'b0}}, out_q};
            2'd1:    rdata_o = {{(DATA_W-GPIO_W){1'b0}}, in_sync_q};
            default: rdata_o = '0;
        endcase
    end

endmodule

/* design/bus_timer.sv */
`timescale 1ns/10ps

module bus_timer import soc_bus_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              we_i,
    input  logic [3:0]        be_i,
    input  logic [1:0]        addr_i,
    input  logic [DATA_W-1:0] wdata_i,
    input  logic              irq_ack_i,
    output logic [DATA_W-1:0] rdata_o,
    output logic              irq_o
);

    timer_reg_e        sel;
    logic [DATA_W-1:0] count_q;
    logic [DATA_W-1:0] compare_q;
    logic [1:0]        ctrl_q;
    logic [DATA_W-1:0] ctrl_next;
    logic              match;

    assign sel       = timer_reg_e'(addr_i);
    assign ctrl_next = apply_be({{(DATA_W-2){1'b0}}, ctrl_q}, wdata_i, be_i);
    assign match     = ctrl_q[1] && (count_q == compare_q);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q   <= '0;
            compare_q <= '0;
            ctrl_q    <= '0;
        end else begin
            // bus write to count wins over the increment
            if (we_i && sel == TMR_COUNT) begin
                count_q <= apply_be(count_q, wdata_i, be_i);
            end else if (ctrl_q[0]) begin
                count_q <= count_q + 1'b1;
            end
            if (we_i && sel == TMR_COMPARE) begin
                compare_q <= apply_be(compare_q, wdata_i, be_i);
            end
            if (we_i && sel == TMR_CTRL) begin
                ctrl_q <= ctrl_next[1:0];
            end
        end
    end

    // sticky irq, ack beats a fresh match
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            irq_o <= 1'b0;
        end else if (irq_ack_i) begin
            irq_o <= 1'b0;
        end else if (match) begin
            irq_o <= 1'b1;
        end
    end

    always_comb begin
        case (sel)
            TMR_COUNT:   rdata_o = count_q;
            TMR_COMPARE: rdata_o = compare_q;
            TMR_CTRL:    rdata_o = {{(DATA_W-2){1'b0}}, ctrl_q};
            default:     rdata_o = '0;
        endcase
    end

endmodule

/* design/data_ram.sv */
`timescale 1ns/10ps

module data_ram import soc_bus_pkg::*; (
    input  logic                         clk_i,
    input  logic                         we_i,
    input  logic [3:0]                   be_i,
    input  logic [$clog2(RAM_WORDS)-1:0] addr_i,
    input  logic [DATA_W-1:0]            wdata_i,
    output logic [DATA_W-1:0]            rdata_o
);

    logic [DATA_W-1:0] mem [RAM_WORDS];

    // byte lanes written independently
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            for (int i = 0; i < 4; i++) begin
                if (be_i[i]) begin
                    mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
                end
            end
        end
    end

    // read port registered every cycle
    always_ff @(posedge clk_i) begin
        rdata_o <= mem[addr_i];
    end

endmodule

/* design/bus_decoder.sv */
`timescale 1ns/10ps

module bus_decoder import soc_bus_pkg::*; #(
    parameter int GPIO_BANKS = 4
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  req_i,
    input  logic                  we_i,
    input  logic [ADDR_W-1:0]     addr_i,
    output logic                  ram_we_o,
    output logic                  timer_we_o,
    output logic [GPIO_BANKS-1:0] gpio_we_o,
    output region_e               rd_region_o,
    output logic [3:0]            rd_bank_o
);

    region_e    region;
    logic [3:0] bank;
    logic       wr;

    assign region = region_of(addr_i[16:13], GPIO_BANKS);
    assign bank   = bank_of(addr_i[16:13]);
    assign wr     = req_i & we_i;

    assign ram_we_o   = wr && (region == REG_RAM);
    assign timer_we_o = wr && (region == REG_TIMER);

    always_comb begin
        for (int b = 0; b < GPIO_BANKS; b++) begin
            gpio_we_o[b] = wr && (region == REG_GPIO0) && (bank == 4'(b));
        end
    end

    // source of the pending read, used by the mux one cycle later
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_region_o <= REG_RSVD;
            rd_bank_o   <= '0;
        end else if (req_i) begin
            rd_region_o <= region;
            rd_bank_o   <= (region == REG_GPIO0) ? bank : 4'd0;
        end
    end

endmodule

/* design/soc_bus_pkg.sv */
package soc_bus_pkg;

    parameter int DATA_W    = 32;
    parameter int ADDR_W    = 32;
    parameter int GPIO_W    = 16;
    parameter int RAM_WORDS = 2048;

    // region code from address bits 16:13
    typedef enum logic [3:0] {
        REG_RAM   = 4'd0,
        REG_RSVD  = 4'd1,
        REG_TIMER = 4'd2,
        REG_GPIO0 = 4'd3
    } region_e;

    // timer word offsets, ctrl bit 0 enable, bit 1 irq enable
    typedef enum logic [1:0] {
        TMR_COUNT   = 2'd0,
        TMR_COMPARE = 2'd1,
        TMR_CTRL    = 2'd2
    } timer_reg_e;

    function automatic region_e region_of(input logic [3:0] code, input int banks);
        region_e r;
        r = REG_RSVD;
        if (code == 4'd0) begin
            r = REG_RAM;
        end else if (code == 4'd2) begin
            r = REG_TIMER;
        end else if (int'(code) >= 3 && int'(code) < 3 + banks) begin
            r = REG_GPIO0;
        end
        return r;
    endfunction

    // only meaningful when the region is a GPIO bank
    function automatic logic [3:0] bank_of(input logic [3:0] code);
        return code - 4'd3;
    endfunction

    function automatic logic [DATA_W-1:0] apply_be(input logic [DATA_W-1:0] old_w,
                                                   input logic [DATA_W-1:0] new_w,
                                                   input logic [3:0]        be);
        logic [DATA_W-1:0] res;
        res = old_w;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return res;
    endfunction

endpackage
